// ==== include/div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ****************************************
// divider sizing
// ****************************************

// operand and result width in bits.
`define DIV_XLEN 64

// one quotient bit is produced per step, so this equals the width.
`define DIV_STEPS 64

// the step counter must hold the value DIV_STEPS itself.
`define DIV_CNT_W 7

`endif

// ==== rtl/div_isa_pkg.sv ====
`include "div_config.svh"

package div_isa_pkg;

  // ****************************************
  // M extension divide operations
  // ****************************************

  // bit 0 marks a signed operation, bit 1 selects the remainder.
  typedef enum logic [1:0] {
    div_op_div  = 2'b01,
    div_op_divu = 2'b00,
    div_op_rem  = 2'b11,
    div_op_remu = 2'b10
  } div_op_e;

  // request as it arrives from the core together with in_valid.
  typedef struct packed {
    div_op_e               op;
    logic [`DIV_XLEN-1:0]  dividend;
    logic [`DIV_XLEN-1:0]  divisor;
  } div_req_t;

endpackage

// ==== rtl/div_dp_pkg.sv ====
`include "div_config.svh"

package div_dp_pkg;

  // ****************************************
  // decode to execute
  // ****************************************

  typedef struct packed {
    logic [`DIV_XLEN-1:0]  dividend_mag;
    logic [`DIV_XLEN-1:0]  divisor_mag;
    // the remainder takes the sign of the dividend.
    logic                  dividend_neg;
    logic                  quot_neg;
    logic                  want_rem;
    logic                  div_by_zero;
    logic                  overflow;
    // needed untouched as the remainder of a divide by zero.
    logic [`DIV_XLEN-1:0]  dividend_raw;
  } div_operands_t;

  // ****************************************
  // execute to result
  // ****************************************

  typedef struct packed {
    logic [`DIV_XLEN-1:0]  quot_mag;
    logic [`DIV_XLEN-1:0]  rem_mag;
    logic                  dividend_neg;
    logic                  quot_neg;
    logic                  want_rem;
    logic                  div_by_zero;
    logic                  overflow;
    logic [`DIV_XLEN-1:0]  dividend_raw;
  } div_raw_t;

endpackage

// ==== rtl/cla_64.sv ====
`timescale 1ns/1ps

module cla_64 (
  input  logic [63:0] a,
  input  logic [63:0] b,
  input  logic        cin,
  output logic [63:0] sum
);

  logic [63:0] g;
  logic [63:0] p;
  logic [63:0] c;
  logic [15:0] grp_g;
  logic [15:0] grp_p;
  logic [15:0] grp_c;
  logic [3:0]  blk_g;
  logic [3:0]  blk_p;
  logic [3:0]  blk_c;

  // carries c1..c4 of a 4-wide slice, returned as {c4, c3, c2, c1}.
  function automatic logic [3:0] la4(input logic [3:0] gi, input logic [3:0] pi,
                                     input logic c0);
    logic [3:0] co;
    co[0] = gi[0] | (pi[0] & c0);
    co[1] = gi[1] | (pi[1] & gi[0]) | (pi[1] & pi[0] & c0);
    co[2] = gi[2] | (pi[2] & gi[1]) | (pi[2] & pi[1] & gi[0]) |
            (pi[2] & pi[1] & pi[0] & c0);
    co[3] = gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1]) |
            (pi[3] & pi[2] & pi[1] & gi[0]) | (&pi & c0);
    return co;
  endfunction

  // slice generate in bit 1, slice propagate in bit 0.
  function automatic logic [1:0] gp4(input logic [3:0] gi, input logic [3:0] pi);
    logic gg;
    gg = gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1]) | (pi[3] & pi[2] & pi[1] & gi[0]);
    return {gg, &pi};
  endfunction

  assign g = a & b;
  assign p = a ^ b;

  always_comb begin
    logic [3:0] la_c;
    for (int k = 0; k < 16; k++) begin
      {grp_g[k], grp_p[k]} = gp4(g[4*k +: 4], p[4*k +: 4]);
    end
    for (int m = 0; m < 4; m++) begin
      {blk_g[m], blk_p[m]} = gp4(grp_g[4*m +: 4], grp_p[4*m +: 4]);
    end

    // carries into the four blocks of sixteen bits at the top level.
    la_c       = la4(blk_g, blk_p, cin);
    blk_c[0]   = cin;
    blk_c[3:1] = la_c[2:0];

    for (int m = 0; m < 4; m++) begin
      la_c              = la4(grp_g[4*m +: 4], grp_p[4*m +: 4], blk_c[m]);
      grp_c[4*m]        = blk_c[m];
      grp_c[4*m+1 +: 3] = la_c[2:0];
    end

    for (int k = 0; k < 16; k++) begin
      la_c          = la4(g[4*k +: 4], p[4*k +: 4], grp_c[k]);
      c[4*k]        = grp_c[k];
      c[4*k+1 +: 3] = la_c[2:0];
    end
  end

  assign sum = p ^ c;

endmodule

// ==== rtl/div_decode.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_decode import div_isa_pkg::*, div_dp_pkg::*; (
  input  div_req_t      req,
  output div_operands_t operands
);

  logic                 is_signed;
  logic                 is_rem;
  logic                 dividend_neg;
  logic                 divisor_neg;
  logic [`DIV_XLEN-1:0] dividend_abs;
  logic [`DIV_XLEN-1:0] divisor_abs;
  logic                 min_dividend;
  logic                 ones_divisor;

  assign is_signed = (req.op == div_op_div) || (req.op == div_op_rem);
  assign is_rem    = (req.op == div_op_rem) || (req.op == div_op_remu);

  // unsigned operands are never treated as negative.
  assign dividend_neg = is_signed && req.dividend[`DIV_XLEN-1];
  assign divisor_neg  = is_signed && req.divisor[`DIV_XLEN-1];

  always_comb begin
    if (dividend_neg) begin
      dividend_abs = ~req.dividend + 1'b1;
    end else begin
      dividend_abs = req.dividend;
    end
    if (divisor_neg) begin
      divisor_abs = ~req.divisor + 1'b1;
    end else begin
      divisor_abs = req.divisor;
    end
  end

  // the only signed quotient that does not fit is min / -1.
  assign min_dividend = (req.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}});
  assign ones_divisor = &req.divisor;

  always_comb begin
    operands.dividend_mag = dividend_abs;
    operands.divisor_mag  = divisor_abs;
    operands.dividend_neg = dividend_neg;
    operands.quot_neg     = dividend_neg ^ divisor_neg;
    operands.want_rem     = is_rem;
    operands.div_by_zero  = (req.divisor == '0);
    operands.overflow     = is_signed && min_dividend && ones_divisor;
    operands.dividend_raw = req.dividend;
  end

endmodule

// ==== rtl/div_iter.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_iter import div_dp_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  div_operands_t operands,
  input  logic          flush,
  output logic          busy,
  output logic          done,
  output div_raw_t      raw
);

  localparam int XLEN = `DIV_XLEN;

  // upper half is the low part of the partial remainder, lower half the
  // dividend bits still to shift in and the quotient bits shifted out.
  logic [2*XLEN-1:0]     rq;
  // the partial remainder needs one bit above the register to hold its sign.
  logic                  rem_sign;
  logic [XLEN-1:0]       div_neg;
  logic [`DIV_CNT_W-1:0] cnt;
  div_operands_t         ops_q;

  logic                  load;
  logic                  stepping;
  logic                  fixing;
  logic [XLEN-1:0]       add_a;
  logic [XLEN-1:0]       add_b;
  logic [XLEN-1:0]       add_sum;
  logic                  a_hi;
  logic                  b_hi;
  logic                  carry_msb;
  logic                  carry_out;
  logic                  sum_sign;

  assign load     = start && !busy && !flush;
  assign stepping = busy && (cnt != '0);
  assign fixing   = busy && (cnt == '0);

  // ****************************************
  // shared adder
  // ****************************************

  always_comb begin
    if (fixing) begin
      // a negative final remainder gets the divisor added back once.
      add_a = rq[2*XLEN-1:XLEN];
      add_b = ops_q.divisor_mag;
      a_hi  = rem_sign;
      b_hi  = 1'b0;
    end else begin
      add_a = {rq[2*XLEN-2:XLEN], rq[XLEN-1]};
      add_b = rem_sign ? ops_q.divisor_mag : div_neg;
      a_hi  = rq[2*XLEN-1];
      b_hi  = rem_sign ? 1'b0 : (|ops_q.divisor_mag);
    end
  end

  cla_64 add_i (
    .a   (add_a),
    .b   (add_b),
    .cin (1'b0),
    .sum (add_sum)
  );

  // rebuild the carry out of the msb so the sign bit can be formed.
  assign carry_msb = add_sum[XLEN-1] ^ add_a[XLEN-1] ^ add_b[XLEN-1];
  assign carry_out = (add_a[XLEN-1] & add_b[XLEN-1]) |
                     ((add_a[XLEN-1] ^ add_b[XLEN-1]) & carry_msb);
  assign sum_sign  = a_hi ^ b_hi ^ carry_out;

  // ****************************************
  // control
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        cnt  <= `DIV_CNT_W'(`DIV_STEPS);
      end else if (stepping) begin
        cnt <= cnt - 1'b1;
      end else if (fixing) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // ****************************************
  // datapath
  // ****************************************

  always_ff @(posedge clk) begin
    if (load) begin
      ops_q    <= operands;
      rq       <= {{XLEN{1'b0}}, operands.dividend_mag};
      rem_sign <= 1'b0;
      div_neg  <= ~operands.divisor_mag + 1'b1;
    end else if (stepping) begin
      // quotient bit is set when the new partial remainder is not negative.
      rem_sign <= sum_sign;
      rq       <= {add_sum, rq[XLEN-2:0], ~sum_sign};
    end else if (fixing) begin
      raw.quot_mag     <= rq[XLEN-1:0];
      raw.rem_mag      <= rem_sign ? add_sum : rq[2*XLEN-1:XLEN];
      raw.dividend_neg <= ops_q.dividend_neg;
      raw.quot_neg     <= ops_q.quot_neg;
      raw.want_rem     <= ops_q.want_rem;
      raw.div_by_zero  <= ops_q.div_by_zero;
      raw.overflow     <= ops_q.overflow;
      raw.dividend_raw <= ops_q.dividend_raw;
    end
  end

endmodule

// ==== rtl/div_result.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_result import div_dp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 done,
  input  div_raw_t             raw,
  input  logic                 flush,
  output logic                 out_valid,
  output logic [`DIV_XLEN-1:0] result
);

  logic [`DIV_XLEN-1:0] quot_val;
  logic [`DIV_XLEN-1:0] rem_val;
  logic [`DIV_XLEN-1:0] final_val;

  always_comb begin
    if (raw.quot_neg) begin
      quot_val = ~raw.quot_mag + 1'b1;
    end else begin
      quot_val = raw.quot_mag;
    end
    if (raw.dividend_neg) begin
      rem_val = ~raw.rem_mag + 1'b1;
    end else begin
      rem_val = raw.rem_mag;
    end

    // the ISA defines both special cases, so no trap is raised.
    if (raw.div_by_zero) begin
      quot_val = '1;
      rem_val  = raw.dividend_raw;
    end else if (raw.overflow) begin
      quot_val = {1'b1, {(`DIV_XLEN-1){1'b0}}};
      rem_val  = '0;
    end

    final_val = raw.want_rem ? rem_val : quot_val;
  end

  // result keeps its value until the next completed operation.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= done && !flush;
      if (done && !flush) begin
        result <= final_val;
      end
    end
  end

endmodule

// ==== rtl/div_unit_top.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_unit_top import div_isa_pkg::*, div_dp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  div_req_t             req,
  input  logic                 flush,
  output logic                 busy,
  output logic                 out_valid,
  output logic [`DIV_XLEN-1:0] result
);

  div_operands_t operands;
  div_raw_t      raw;
  logic          done;

  div_decode decode_i (
    .req      (req),
    .operands (operands)
  );

  // strobes that arrive while busy is high are dropped here.
  div_iter iter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (in_valid),
    .operands (operands),
    .flush    (flush),
    .busy     (busy),
    .done     (done),
    .raw      (raw)
  );

  div_result result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .raw       (raw),
    .flush     (flush),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

// ==== tb/div_unit_tb.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_unit_tb import div_isa_pkg::*; ();

  localparam int XLEN         = `DIV_XLEN;
  localparam int LATENCY      = 66;
  localparam int MAX_WAIT     = 80;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_SIGNED   = 2 * 4 * 4;
  localparam int NUM_SPECIAL  = 4 * 3 + 4;
  localparam int NUM_TRIALS   = 4;
  // each flush or dropped-strobe trial takes up to three request slots.
  localparam int NUM_REQ = NUM_RANDOM + NUM_SIGNED + NUM_SPECIAL + 2 * 3 * NUM_TRIALS;

  localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_VAL = {1'b0, {(XLEN-1){1'b1}}};
  localparam logic [XLEN-1:0] ONE_VAL = {{(XLEN-1){1'b0}}, 1'b1};

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  div_req_t        req;
  logic            flush;
  logic            busy;
  logic            out_valid;
  logic [XLEN-1:0] result;

  int value_errors;
  int other_errors;

  div_unit_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .flush     (flush),
    .busy      (busy),
    .out_valid (out_valid),
    .result    (result)
  );

  always #4 clk = ~clk;

  // ****************************************
  // reference model and stimulus helpers
  // ****************************************

  // RISC-V M extension division, including the two special cases.
  function automatic logic [XLEN-1:0] model_result(input div_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic                   is_signed;
    logic                   is_rem;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [XLEN-1:0]        q;
    logic [XLEN-1:0]        r;
    is_signed = (op == div_op_div) || (op == div_op_rem);
    is_rem    = (op == div_op_rem) || (op == div_op_remu);
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (is_signed && (a == MIN_VAL) && (b == '1)) begin
      q = MIN_VAL;
      r = '0;
    end else if (is_signed) begin
      // signed division truncates toward zero, so the remainder follows the dividend.
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
    return is_rem ? r : q;
  endfunction

  function automatic div_op_e rand_op();
    logic [1:0] code;
    code = 2'($urandom % 4);
    return div_op_e'(code);
  endfunction

  // mixes edge values with full-width and shortened random words.
  function automatic logic [XLEN-1:0] rand_operand();
    logic [XLEN-1:0] v;
    v = {$urandom, $urandom};
    case ($urandom % 8)
      0: v = '0;
      1: v = '1;
      2: v = MIN_VAL;
      3: v = MAX_VAL;
      4, 5: v = v >> ($urandom % XLEN);
      default: v = v;
    endcase
    return v;
  endfunction

  // ****************************************
  // request and response tasks
  // ****************************************

  // returns at the falling edge right after the edge that sampled the strobe.
  task automatic start_request(input div_op_e op, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b);
    req.op       = op;
    req.dividend = a;
    req.divisor  = b;
    in_valid     = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic expect_result(input div_op_e op, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b, input int first_cycle);
    logic [XLEN-1:0] expected;
    int              cycles;
    expected = model_result(op, a, b);
    cycles   = first_cycle;
    while (!out_valid && (cycles < MAX_WAIT)) begin
      @(negedge clk);
      cycles++;
    end
    assert (out_valid) else begin
      $display("no out_valid within %0d cycles of the request", MAX_WAIT);
      other_errors++;
    end
    assert (cycles == LATENCY) else begin
      $display("out_valid came %0d cycles after the request instead of %0d", cycles, LATENCY);
      other_errors++;
    end
    assert (result == expected) else begin
      $display("FAIL result: %s %h, %h expected %h, got %h", op.name(), a, b, expected, result);
      value_errors++;
    end
    @(negedge clk);
    assert (!out_valid) else begin
      $display("FAIL out_valid: expected 0, got %h one cycle after the pulse", out_valid);
      value_errors++;
    end
  endtask

  task automatic run_request(input div_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
    start_request(op, a, b);
    expect_result(op, a, b, 0);
  endtask

  task automatic flush_trial();
    int              wait_cycles;
    logic            stray;
    div_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    op          = rand_op();
    a           = rand_operand();
    b           = rand_operand();
    wait_cycles = 2 + int'($urandom % 55);
    start_request(op, a, b);
    repeat (wait_cycles) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (!busy) else begin
      $display("FAIL busy: expected 0, got %h after flush", busy);
      value_errors++;
    end
    stray = 1'b0;
    repeat (MAX_WAIT) begin
      @(negedge clk);
      stray = stray | out_valid;
    end
    assert (!stray) else begin
      $display("out_valid pulsed for a flushed request");
      other_errors++;
    end
    run_request(rand_op(), rand_operand(), rand_operand());
  endtask

  task automatic strobe_trial();
    int              wait_cycles;
    int              pulses;
    div_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] expected;
    op          = rand_op();
    a           = rand_operand();
    b           = rand_operand();
    expected    = model_result(op, a, b);
    wait_cycles = 1 + int'($urandom % 60);
    start_request(op, a, b);
    repeat (wait_cycles) @(negedge clk);
    assert (busy) else begin
      $display("FAIL busy: expected 1, got %h while an operation was running", busy);
      value_errors++;
    end
    // this strobe arrives while busy and has to be dropped.
    start_request(div_op_e'(op ^ 2'b11), rand_operand(), rand_operand());
    expect_result(op, a, b, wait_cycles + 1);
    pulses = 0;
    repeat (MAX_WAIT) begin
      @(negedge clk);
      if (out_valid) begin
        pulses++;
      end
    end
    assert (pulses == 0) else begin
      $display("a strobe sent while busy produced %0d extra out_valid pulses", pulses);
      other_errors++;
    end
    assert (result == expected) else begin
      $display("FAIL result: expected %h, got %h after the dropped strobe", expected, result);
      value_errors++;
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    void'($urandom(89));
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    req          = '0;
    flush        = 1'b0;
    value_errors = 0;
    other_errors = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    assert (!busy && !out_valid) else begin
      $display("FAIL busy/out_valid: expected 0/0, got %h/%h after reset", busy, out_valid);
      value_errors++;
    end
    assert (result == '0) else begin
      $display("FAIL result: expected %h, got %h after reset", {XLEN{1'b0}}, result);
      value_errors++;
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      run_request(rand_op(), rand_operand(), rand_operand());
    end

    // every sign combination, with the extreme values in some draws.
    for (int s = 0; s < 4; s++) begin
      for (int d = 0; d < 4; d++) begin
        a = rand_operand() & MAX_VAL;
        b = (rand_operand() & MAX_VAL) >> ($urandom % 40);
        if (d == 0) begin
          a = MAX_VAL;
        end
        if (d == 1) begin
          b = MAX_VAL;
        end
        if (b == '0) begin
          b = ONE_VAL;
        end
        if (s[1]) begin
          a = (d == 0) ? MIN_VAL : -a;
        end
        if (s[0]) begin
          b = (d == 1) ? MIN_VAL : -b;
        end
        run_request(div_op_div, a, b);
        run_request(div_op_rem, a, b);
      end
    end

    for (int k = 0; k < 3; k++) begin
      a = (k == 0) ? MIN_VAL : rand_operand();
      run_request(div_op_div, a, '0);
      run_request(div_op_divu, a, '0);
      run_request(div_op_rem, a, '0);
      run_request(div_op_remu, a, '0);
    end

    run_request(div_op_div, MIN_VAL, '1);
    run_request(div_op_rem, MIN_VAL, '1);
    run_request(div_op_divu, MIN_VAL, '1);
    run_request(div_op_remu, MIN_VAL, '1);

    for (int t = 0; t < NUM_TRIALS; t++) begin
      flush_trial();
      strobe_trial();
    end

    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if ((value_errors + other_errors) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + NUM_REQ * MAX_WAIT) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
rtl/div_isa_pkg.sv
rtl/div_dp_pkg.sv
rtl/cla_64.sv
rtl/div_decode.sv
rtl/div_iter.sv
rtl/div_result.sv
rtl/div_unit_top.sv
tb/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the divider testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module div_unit_tb -Mdir "$OBJ" -o div_unit_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ/div_unit_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0
